// ==== verification/rvid_stimulus.txt ====
# id instr pc rf_a rf_b wdata_ex wdata_wb sel_a sel_b ctrl(valid kill halt ldst jr exrdy bdec)
# flags(rdy vld brtk exvalid rf_we req we illegal sext) alu_op rd dtype opa opb opc jmp perf(bin)
1 002081b3 00000100 11111111 22222222 33333333 44444444 1 2 1000010 110110000 0 3 0 33333333 44444444 44444444 00000902 1000000
2 407302b3 00000104 11111111 22222222 33333333 44444444 0 0 1000010 110110000 1 5 0 11111111 22222222 22222222 00000d08 1000000
3 fff08213 00000108 11111111 22222222 33333333 44444444 0 0 1000010 110110000 0 4 0 11111111 ffffffff 22222222 fffff8ec 1000000
4 123453b7 0000010c 11111111 22222222 33333333 44444444 0 0 1000010 110110000 0 7 0 00000000 12345000 22222222 00000a32 1000000
5 fffff417 00000110 11111111 22222222 33333333 44444444 0 0 1000010 110110000 0 8 0 00000110 fffff000 22222222 fffff8f8 1000000
6 fe20ae23 00000114 11111111 22222222 33333333 44444444 0 1 1000010 110101100 0 8 2 11111111 fffffffc 33333333 fffff910 1010000
7 0080c483 00000118 11111111 22222222 33333333 44444444 2 0 1000010 110111000 0 9 0 44444444 00000008 22222222 00000920 1100000
8 ffe11503 0000011c 11111111 22222222 33333333 44444444 0 0 1000010 110111001 0 a 1 11111111 fffffffe 22222222 fffff906 1100000
9 010000ef 00000120 11111111 22222222 33333333 44444444 0 0 1000010 110110001 0 1 1 00000120 00000004 22222222 00000130 1001000
10 003082e7 00000124 11111111 22222222 33333333 44444444 1 0 1000010 110110001 0 5 1 00000124 00000004 22222222 33333336 1001000
11 02208063 00000128 11111111 22222222 33333333 44444444 0 0 1000010 110100001 a 5 1 11111111 22222222 00000148 00000148 1000100
12 02208063 00000128 11111111 22222222 33333333 44444444 0 0 0000011 101000001 a 5 1 11111111 22222222 00000148 00000148 0000010
13 002081b3 00000100 11111111 22222222 33333333 44444444 1 2 1000010 110110001 0 3 1 33333333 44444444 44444444 00000902 1000000
14 407302b3 00000104 11111111 22222222 33333333 44444444 0 0 1000000 000110001 0 3 1 33333333 44444444 44444444 00000d08 0000000
15 407302b3 00000104 11111111 22222222 33333333 44444444 0 0 1000010 110110001 1 5 1 11111111 22222222 22222222 00000d08 1000000
16 407302b3 00000104 11111111 22222222 33333333 44444444 0 0 1001010 000010001 1 5 1 11111111 22222222 22222222 00000d08 0000001
17 407302b3 00000104 11111111 22222222 33333333 44444444 0 0 1100010 100010001 1 5 1 11111111 22222222 22222222 00000d08 0000000
18 0000007f 00000200 11111111 22222222 33333333 44444444 0 0 1000010 110100011 1 5 1 11111111 22222222 22222222 00000200 0000000

// ==== rvid.f ====
+incdir+design
design/rvid_pkg.sv
design/rvid_decoder.sv
design/rvid_operand_builder.sv
design/rvid_id_ex_pipe.sv
design/rvid_perf_events.sv
design/rvid_id_stage.sv
verification/rvid_id_stage_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= rvid.f
TB_TOP     ?= rvid_id_stage_tb
RTL_TOP    ?= rvid_id_stage
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary -j 0
PASS_TEXT  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -Idesign design/rvid_pkg.sv \
	design/rvid_decoder.sv design/rvid_operand_builder.sv design/rvid_id_ex_pipe.sv \
	design/rvid_perf_events.sv design/rvid_id_stage.sv

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/rvid_id_stage_tb.sv ====
//////////////////////////////
// Self-checking testbench for the decode
// stage, vectors from the stimulus file
//////////////////////////////
`timescale 1ns/10ps
`include "rvid_macros.svh"

module rvid_id_stage_tb;

  logic                    clk;
  logic                    rst_n;
  rvid_pkg::if_id_t        if_id;
  rvid_pkg::fwd_data_t     fwd;
  logic                    kill_id;
  logic                    halt_id;
  logic                    load_stall;
  logic                    jr_stall;
  logic                    ex_ready;
  logic                    branch_decision;
  rvid_pkg::id_ex_t        id_ex;
  logic                    id_ready;
  logic                    id_valid;
  logic                    clear_instr_valid;
  logic                    branch_taken_ex;
  logic [`RVID_XLEN-1:0]   jmp_target;
  logic [`RVID_REG_AW-1:0] rf_raddr_a;
  logic [`RVID_REG_AW-1:0] rf_raddr_b;
  rvid_pkg::perf_evt_t     perf;

  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;

  rvid_id_stage dut_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .if_id_i             (if_id),
    .fwd_i               (fwd),
    .kill_id_i           (kill_id),
    .halt_id_i           (halt_id),
    .load_stall_i        (load_stall),
    .jr_stall_i          (jr_stall),
    .ex_ready_i          (ex_ready),
    .branch_decision_i   (branch_decision),
    .id_ex_o             (id_ex),
    .id_ready_o          (id_ready),
    .id_valid_o          (id_valid),
    .clear_instr_valid_o (clear_instr_valid),
    .branch_taken_ex_o   (branch_taken_ex),
    .jmp_target_o        (jmp_target),
    .rf_raddr_a_o        (rf_raddr_a),
    .rf_raddr_b_o        (rf_raddr_b),
    .perf_o              (perf)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // Compare one observed value with its expected value
  task automatic compare(input int id, input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error test %0d: %s got %h expected %h", id, name, got, exp);
      test_errors++;
    end
  endtask

  //////////////////////////////
  // Vector replay
  //////////////////////////////

  initial begin
    int          fd;
    int          n;
    int          cycles;
    string       line;
    int          id;
    logic        run_ok;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rfa;
    logic [31:0] rfb;
    logic [31:0] wex;
    logic [31:0] wwb;
    logic [31:0] sel_a;
    logic [31:0] sel_b;
    logic [6:0]  ctrl;
    logic [8:0]  flags;
    logic [31:0] alu_op;
    logic [31:0] rd;
    logic [31:0] dtype;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] opc;
    logic [31:0] jmp;
    logic [6:0]  perf_exp;
    logic [31:0] exp_pc;
    logic        exp_alu_en;
    logic        exp_branch;

    clk             = 1'b0;
    rst_n           = 1'b0;
    if_id           = '0;
    fwd             = '0;
    kill_id         = 1'b0;
    halt_id         = 1'b0;
    load_stall      = 1'b0;
    jr_stall        = 1'b0;
    ex_ready        = 1'b1;
    branch_decision = 1'b0;
    total_errors    = 0;
    tests_run       = 0;
    tests_failed    = 0;
    run_ok          = 1'b1;
    exp_pc          = '0;
    exp_alu_en      = 1'b0;
    exp_branch      = 1'b0;

    fd = $fopen("verification/rvid_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file verification/rvid_stimulus.txt");
      run_ok = 1'b0;
    end

    // Reset for 2 cycles, released away from the rising edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Registered outputs come out of reset cleared
    test_errors = 0;
    compare(0, "id_ex_o.instr_valid", id_ex.instr_valid, 1'b0);
    compare(0, "id_ex_o.alu_en", id_ex.alu_en, 1'b0);
    compare(0, "id_ex_o.rf_we", id_ex.rf_we, 1'b0);
    compare(0, "id_ex_o.data_req", id_ex.data_req, 1'b0);
    compare(0, "id_ex_o.alu_op", id_ex.alu_op, rvid_pkg::ALU_ADD);
    compare(0, "perf_o", perf, 7'h00);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("reset check ok");
    end else begin
      tests_failed++;
      $display("reset check failed with %0d mismatches", test_errors);
    end

    // Stage must report ready once out of reset
    cycles = 0;
    while (!id_ready && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!id_ready) begin
      $display("Stage never became ready after reset");
      run_ok = 1'b0;
    end

    while (run_ok && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 1 || line.substr(0, 0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %b %b %h %h %h %h %h %h %h %b",
                  id, instr, pc, rfa, rfb, wex, wwb, sel_a, sel_b, ctrl, flags,
                  alu_op, rd, dtype, opa, opb, opc, jmp, perf_exp);
      if (n != 19) begin
        $display("Malformed vector line: %s", line);
        total_errors++;
        continue;
      end
      test_errors = 0;

      // Drive on the falling edge
      if_id.instr_valid = ctrl[6];
      if_id.instr       = instr;
      if_id.pc          = pc;
      fwd.rf_rdata_a    = rfa;
      fwd.rf_rdata_b    = rfb;
      fwd.wdata_ex      = wex;
      fwd.wdata_wb      = wwb;
      fwd.sel_a         = rvid_pkg::fw_sel_e'(sel_a[1:0]);
      fwd.sel_b         = rvid_pkg::fw_sel_e'(sel_b[1:0]);
      kill_id           = ctrl[5];
      halt_id           = ctrl[4];
      load_stall        = ctrl[3];
      jr_stall          = ctrl[2];
      ex_ready          = ctrl[1];
      branch_decision   = ctrl[0];

      // Combinational outputs for this input
      #1;
      compare(id, "id_ready_o", id_ready, flags[8]);
      compare(id, "id_valid_o", id_valid, flags[7]);
      compare(id, "branch_taken_ex_o", branch_taken_ex, flags[6]);
      compare(id, "clear_instr_valid_o", clear_instr_valid, flags[8] | flags[6]);
      compare(id, "jmp_target_o", jmp_target, jmp);
      compare(id, "rf_raddr_a_o", rf_raddr_a, instr[19:15]);
      compare(id, "rf_raddr_b_o", rf_raddr_b, instr[24:20]);

      // Fields without a vector column, loaded only on acceptance
      if (flags[7]) begin
        exp_pc     = pc;
        exp_alu_en = !flags[1];
        exp_branch = (instr[6:0] == rvid_pkg::OPC_BRANCH);
      end

      // Registered state after the next rising edge
      @(negedge clk);
      compare(id, "id_ex_o.instr_valid", id_ex.instr_valid, flags[5]);
      compare(id, "id_ex_o.alu_en", id_ex.alu_en, exp_alu_en);
      compare(id, "id_ex_o.rf_we", id_ex.rf_we, flags[4]);
      compare(id, "id_ex_o.data_req", id_ex.data_req, flags[3]);
      compare(id, "id_ex_o.data_we", id_ex.data_we, flags[2]);
      compare(id, "id_ex_o.illegal", id_ex.illegal, flags[1]);
      compare(id, "id_ex_o.data_sign_ext", id_ex.data_sign_ext, flags[0]);
      compare(id, "id_ex_o.alu_op", id_ex.alu_op, alu_op);
      compare(id, "id_ex_o.rf_waddr", id_ex.rf_waddr, rd);
      compare(id, "id_ex_o.data_type", id_ex.data_type, dtype);
      compare(id, "id_ex_o.operand_a", id_ex.operand_a, opa);
      compare(id, "id_ex_o.operand_b", id_ex.operand_b, opb);
      compare(id, "id_ex_o.operand_c", id_ex.operand_c, opc);
      compare(id, "id_ex_o.branch_in_ex", id_ex.branch_in_ex, exp_branch);
      compare(id, "id_ex_o.pc", id_ex.pc, exp_pc);
      compare(id, "perf_o", perf, perf_exp);

      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
        $display("test %0d ok", id);
      end else begin
        tests_failed++;
        $display("test %0d failed with %0d mismatches", id, test_errors);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (run_ok && total_errors == 0 && tests_run > 1) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== design/rvid_id_stage.sv ====
//////////////////////////////
// Decode stage top, decoder, operand
// builder, ID/EX register, perf events
//////////////////////////////
`timescale 1ns/10ps
`include "rvid_macros.svh"

module rvid_id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rvid_pkg::if_id_t        if_id_i,
  input  rvid_pkg::fwd_data_t     fwd_i,
  input  logic                    kill_id_i,
  input  logic                    halt_id_i,
  input  logic                    load_stall_i,
  input  logic                    jr_stall_i,
  input  logic                    ex_ready_i,
  input  logic                    branch_decision_i,
  output rvid_pkg::id_ex_t        id_ex_o,
  output logic                    id_ready_o,
  output logic                    id_valid_o,
  output logic                    clear_instr_valid_o,
  output logic                    branch_taken_ex_o,
  output logic [`RVID_XLEN-1:0]   jmp_target_o,
  output logic [`RVID_REG_AW-1:0] rf_raddr_a_o,
  output logic [`RVID_REG_AW-1:0] rf_raddr_b_o,
  output rvid_pkg::perf_evt_t     perf_o
);

  rvid_pkg::decode_t     dec;
  logic [`RVID_XLEN-1:0] operand_a;
  logic [`RVID_XLEN-1:0] operand_b;
  logic [`RVID_XLEN-1:0] operand_c;
  logic                  accept;

  // Register file read ports straight from the fields
  assign rf_raddr_a_o = if_id_i.instr[`RVID_RS1_MSB:`RVID_RS1_LSB];
  assign rf_raddr_b_o = if_id_i.instr[`RVID_RS2_MSB:`RVID_RS2_LSB];

  rvid_decoder decoder_i (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  rvid_operand_builder operand_builder_i (
    .instr_i      (if_id_i.instr),
    .pc_i         (if_id_i.pc),
    .fwd_i        (fwd_i),
    .dec_i        (dec),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  rvid_id_ex_pipe id_ex_pipe_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .if_id_i             (if_id_i),
    .dec_i               (dec),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .operand_c_i         (operand_c),
    .kill_id_i           (kill_id_i),
    .halt_id_i           (halt_id_i),
    .load_stall_i        (load_stall_i),
    .jr_stall_i          (jr_stall_i),
    .ex_ready_i          (ex_ready_i),
    .branch_decision_i   (branch_decision_i),
    .id_ex_o             (id_ex_o),
    .id_ready_o          (id_ready_o),
    .id_valid_o          (id_valid_o),
    .clear_instr_valid_o (clear_instr_valid_o),
    .branch_taken_ex_o   (branch_taken_ex_o),
    .accept_o            (accept)
  );

  rvid_perf_events perf_events_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .accept_i          (accept),
    .dec_i             (dec),
    .branch_decision_i (branch_decision_i),
    .load_stall_i      (load_stall_i),
    .halt_id_i         (halt_id_i),
    .perf_o            (perf_o)
  );

endmodule

// ==== design/rvid_perf_events.sv ====
//////////////////////////////
// Registered performance event pulses
//////////////////////////////
`timescale 1ns/10ps

module rvid_perf_events (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                accept_i,
  input  rvid_pkg::decode_t   dec_i,
  input  logic                branch_decision_i,
  input  logic                load_stall_i,
  input  logic                halt_id_i,
  output rvid_pkg::perf_evt_t perf_o
);

  logic minstret;
  logic accept_q;

  // Illegal instructions never count as retired
  assign minstret = accept_i && !dec_i.illegal;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accept_q <= 1'b0;
      perf_o   <= '0;
    end else begin
      // Only the first stalled cycle after an issue counts
      accept_q            <= accept_i;
      perf_o.minstret     <= minstret;
      perf_o.load         <= minstret && dec_i.data_req && !dec_i.data_we;
      perf_o.store        <= minstret && dec_i.data_req && dec_i.data_we;
      perf_o.jump         <= minstret && ((dec_i.ctrl_xfer == rvid_pkg::XFER_JAL) ||
                                          (dec_i.ctrl_xfer == rvid_pkg::XFER_JALR));
      perf_o.branch       <= minstret && (dec_i.ctrl_xfer == rvid_pkg::XFER_COND);
      // Branch sits in EX while its pulse is up
      perf_o.branch_taken <= perf_o.branch && branch_decision_i;
      perf_o.ld_stall     <= load_stall_i && !halt_id_i && accept_q;
    end
  end

endmodule

// ==== design/rvid_id_ex_pipe.sv ====
//////////////////////////////
// ID/EX pipeline register with
// stall and ready/valid control
//////////////////////////////
`timescale 1ns/10ps
`include "rvid_macros.svh"

module rvid_id_ex_pipe (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rvid_pkg::if_id_t      if_id_i,
  input  rvid_pkg::decode_t     dec_i,
  input  logic [`RVID_XLEN-1:0] operand_a_i,
  input  logic [`RVID_XLEN-1:0] operand_b_i,
  input  logic [`RVID_XLEN-1:0] operand_c_i,
  input  logic                  kill_id_i,
  input  logic                  halt_id_i,
  input  logic                  load_stall_i,
  input  logic                  jr_stall_i,
  input  logic                  ex_ready_i,
  input  logic                  branch_decision_i,
  output rvid_pkg::id_ex_t      id_ex_o,
  output logic                  id_ready_o,
  output logic                  id_valid_o,
  output logic                  clear_instr_valid_o,
  output logic                  branch_taken_ex_o,
  output logic                  accept_o
);

  // Stage can move on only when EX takes data and nothing holds ID
  assign id_ready_o = ex_ready_i && !halt_id_i && !load_stall_i && !jr_stall_i;
  assign id_valid_o = if_id_i.instr_valid && !kill_id_i && id_ready_o;
  assign accept_o   = id_valid_o;

  // Branch resolved taken in EX this cycle
  assign branch_taken_ex_o   = id_ex_o.branch_in_ex && id_ex_o.instr_valid && branch_decision_i;
  // IF drops its instruction once consumed or flushed
  assign clear_instr_valid_o = id_ready_o || branch_taken_ex_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o        <= '0;
      id_ex_o.alu_op <= rvid_pkg::ALU_ADD;
    end else if (id_valid_o) begin
      id_ex_o.instr_valid <= 1'b1;
      // Operands only move when the ALU uses them
      id_ex_o.alu_en      <= dec_i.alu_en;
      if (dec_i.alu_en) begin
        id_ex_o.alu_op    <= dec_i.alu_op;
        id_ex_o.operand_a <= operand_a_i;
        id_ex_o.operand_b <= operand_b_i;
        id_ex_o.operand_c <= operand_c_i;
      end
      id_ex_o.rf_we <= dec_i.rf_we;
      if (dec_i.rf_we) begin
        id_ex_o.rf_waddr <= if_id_i.instr[`RVID_RD_MSB:`RVID_RD_LSB];
      end
      // LSU fields only for an active request
      id_ex_o.data_req <= dec_i.data_req;
      if (dec_i.data_req) begin
        id_ex_o.data_we       <= dec_i.data_we;
        id_ex_o.data_type     <= dec_i.data_type;
        id_ex_o.data_sign_ext <= dec_i.data_sign_ext;
      end
      id_ex_o.branch_in_ex <= (dec_i.ctrl_xfer == rvid_pkg::XFER_COND);
      id_ex_o.illegal      <= dec_i.illegal;
      id_ex_o.pc           <= if_id_i.pc;
    end else if (ex_ready_i) begin
      // EX drained and nothing new, bubble
      id_ex_o.instr_valid <= 1'b0;
    end
  end

endmodule

// ==== design/rvid_operand_builder.sv ====
//////////////////////////////
// Immediates, forwarding muxes, operand
// A/B/C muxes and jump/branch targets
//////////////////////////////
`timescale 1ns/10ps
`include "rvid_macros.svh"

module rvid_operand_builder (
  input  logic [`RVID_XLEN-1:0] instr_i,
  input  logic [`RVID_XLEN-1:0] pc_i,
  input  rvid_pkg::fwd_data_t   fwd_i,
  input  rvid_pkg::decode_t     dec_i,
  output logic [`RVID_XLEN-1:0] operand_a_o,
  output logic [`RVID_XLEN-1:0] operand_b_o,
  output logic [`RVID_XLEN-1:0] operand_c_o,
  output logic [`RVID_XLEN-1:0] jmp_target_o
);

  logic [`RVID_XLEN-1:0] imm_i_type;
  logic [`RVID_XLEN-1:0] imm_s_type;
  logic [`RVID_XLEN-1:0] imm_b_type;
  logic [`RVID_XLEN-1:0] imm_u_type;
  logic [`RVID_XLEN-1:0] imm_j_type;
  logic [`RVID_XLEN-1:0] imm;
  logic [`RVID_XLEN-1:0] rs1_fw;
  logic [`RVID_XLEN-1:0] rs2_fw;
  logic [`RVID_XLEN-1:0] bch_target;
  logic [`RVID_XLEN-1:0] jalr_target;

  // Pick the freshest copy of a source register
  function automatic logic [`RVID_XLEN-1:0] fw_mux(
    input rvid_pkg::fw_sel_e     sel,
    input logic [`RVID_XLEN-1:0] rf_rdata,
    input logic [`RVID_XLEN-1:0] wdata_ex,
    input logic [`RVID_XLEN-1:0] wdata_wb
  );
    case (sel)
      rvid_pkg::FW_EX: return wdata_ex;
      rvid_pkg::FW_WB: return wdata_wb;
      default:         return rf_rdata;
    endcase
  endfunction

  //////////////////////////////
  // Immediates
  //////////////////////////////

  // All immediates sign extend from bit 31
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:`RVID_RS2_LSB]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[`RVID_RD_MSB:`RVID_RD_LSB]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    case (dec_i.imm_sel)
      rvid_pkg::IMM_S:      imm = imm_s_type;
      rvid_pkg::IMM_U:      imm = imm_u_type;
      rvid_pkg::IMM_PCINCR: imm = `RVID_XLEN'(`RVID_PC_INCR);
      default:              imm = imm_i_type;
    endcase
  end

  //////////////////////////////
  // Operands
  //////////////////////////////

  assign rs1_fw = fw_mux(fwd_i.sel_a, fwd_i.rf_rdata_a, fwd_i.wdata_ex, fwd_i.wdata_wb);
  assign rs2_fw = fw_mux(fwd_i.sel_b, fwd_i.rf_rdata_b, fwd_i.wdata_ex, fwd_i.wdata_wb);

  always_comb begin
    case (dec_i.op_a_sel)
      rvid_pkg::OP_A_PC:   operand_a_o = pc_i;
      rvid_pkg::OP_A_ZERO: operand_a_o = '0;
      default:             operand_a_o = rs1_fw;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == rvid_pkg::OP_B_IMM) ? imm : rs2_fw;
  // Store data or branch target for EX
  assign operand_c_o = (dec_i.op_c_sel == rvid_pkg::OP_C_BCH_TARGET) ? bch_target : rs2_fw;

  // Targets, JALR base only via the operand A bypass
  assign bch_target  = pc_i + imm_b_type;
  assign jalr_target = (rs1_fw + imm_i_type) & ~`RVID_XLEN'(1);

  always_comb begin
    case (dec_i.ctrl_xfer)
      rvid_pkg::XFER_JAL:  jmp_target_o = pc_i + imm_j_type;
      rvid_pkg::XFER_JALR: jmp_target_o = jalr_target;
      default:             jmp_target_o = bch_target;
    endcase
  end

endmodule

// ==== design/rvid_decoder.sv ====
//////////////////////////////
// RV32I decoder, instruction word to
// decode control struct
//////////////////////////////
`timescale 1ns/10ps
`include "rvid_macros.svh"

module rvid_decoder (
  input  logic [`RVID_XLEN-1:0] instr_i,
  output rvid_pkg::decode_t     dec_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Start from a side-effect free default
    dec_o               = '0;
    dec_o.alu_op        = rvid_pkg::ALU_ADD;
    dec_o.op_a_sel      = rvid_pkg::OP_A_REG;
    dec_o.op_b_sel      = rvid_pkg::OP_B_REG;
    dec_o.op_c_sel      = rvid_pkg::OP_C_REG_B;
    dec_o.imm_sel       = rvid_pkg::IMM_I;
    dec_o.ctrl_xfer     = rvid_pkg::XFER_NONE;

    case (rvid_pkg::opcode_e'(instr_i[`RVID_OPC_W-1:0]))
      rvid_pkg::OPC_LUI: begin
        // rd = 0 + imm
        dec_o.alu_en    = 1'b1;
        dec_o.op_a_sel  = rvid_pkg::OP_A_ZERO;
        dec_o.op_b_sel  = rvid_pkg::OP_B_IMM;
        dec_o.imm_sel   = rvid_pkg::IMM_U;
        dec_o.rf_we     = 1'b1;
      end
      rvid_pkg::OPC_AUIPC: begin
        // rd = pc + imm
        dec_o.alu_en    = 1'b1;
        dec_o.op_a_sel  = rvid_pkg::OP_A_PC;
        dec_o.op_b_sel  = rvid_pkg::OP_B_IMM;
        dec_o.imm_sel   = rvid_pkg::IMM_U;
        dec_o.rf_we     = 1'b1;
      end
      rvid_pkg::OPC_JAL, rvid_pkg::OPC_JALR: begin
        // Link address pc + 4 goes through the ALU, target is computed aside
        dec_o.alu_en    = 1'b1;
        dec_o.op_a_sel  = rvid_pkg::OP_A_PC;
        dec_o.op_b_sel  = rvid_pkg::OP_B_IMM;
        dec_o.imm_sel   = rvid_pkg::IMM_PCINCR;
        dec_o.rf_we     = 1'b1;
        if (instr_i[3]) begin
          dec_o.ctrl_xfer = rvid_pkg::XFER_JAL;
        end else begin
          dec_o.ctrl_xfer = rvid_pkg::XFER_JALR;
          dec_o.illegal   = (funct3 != 3'b000);
        end
      end
      rvid_pkg::OPC_BRANCH: begin
        // Compare rs1 with rs2, target travels in operand C
        dec_o.alu_en    = 1'b1;
        dec_o.op_c_sel  = rvid_pkg::OP_C_BCH_TARGET;
        dec_o.ctrl_xfer = rvid_pkg::XFER_COND;
        case (funct3)
          3'b000:  dec_o.alu_op = rvid_pkg::ALU_EQ;
          3'b001:  dec_o.alu_op = rvid_pkg::ALU_NE;
          3'b100:  dec_o.alu_op = rvid_pkg::ALU_LT;
          3'b101:  dec_o.alu_op = rvid_pkg::ALU_GE;
          3'b110:  dec_o.alu_op = rvid_pkg::ALU_LTU;
          3'b111:  dec_o.alu_op = rvid_pkg::ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end
      rvid_pkg::OPC_LOAD: begin
        // Address = rs1 + I, funct3[2] means zero extension
        dec_o.alu_en        = 1'b1;
        dec_o.op_b_sel      = rvid_pkg::OP_B_IMM;
        dec_o.rf_we         = 1'b1;
        dec_o.data_req      = 1'b1;
        dec_o.data_type     = funct3[1:0];
        dec_o.data_sign_ext = ~funct3[2];
        // LD and the unsigned word form do not exist in RV32I
        dec_o.illegal       = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      rvid_pkg::OPC_STORE: begin
        // Address = rs1 + S, data is rs2 in operand C
        dec_o.alu_en    = 1'b1;
        dec_o.op_b_sel  = rvid_pkg::OP_B_IMM;
        dec_o.imm_sel   = rvid_pkg::IMM_S;
        dec_o.data_req  = 1'b1;
        dec_o.data_we   = 1'b1;
        dec_o.data_type = funct3[1:0];
        dec_o.illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      rvid_pkg::OPC_OP_IMM: begin
        dec_o.alu_en    = 1'b1;
        dec_o.op_b_sel  = rvid_pkg::OP_B_IMM;
        dec_o.rf_we     = 1'b1;
        case (funct3)
          3'b000: dec_o.alu_op = rvid_pkg::ALU_ADD;
          3'b010: dec_o.alu_op = rvid_pkg::ALU_SLT;
          3'b011: dec_o.alu_op = rvid_pkg::ALU_SLTU;
          3'b100: dec_o.alu_op = rvid_pkg::ALU_XOR;
          3'b110: dec_o.alu_op = rvid_pkg::ALU_OR;
          3'b111: dec_o.alu_op = rvid_pkg::ALU_AND;
          3'b001: begin
            // Shift amount sits in imm[4:0], upper bits must be zero
            dec_o.alu_op  = rvid_pkg::ALU_SLL;
            dec_o.illegal = (funct7 != 7'h00);
          end
          default: begin
            // funct7 picks logical or arithmetic right shift
            if (funct7 == 7'h00) begin
              dec_o.alu_op = rvid_pkg::ALU_SRL;
            end else if (funct7 == 7'h20) begin
              dec_o.alu_op = rvid_pkg::ALU_SRA;
            end else begin
              dec_o.illegal = 1'b1;
            end
          end
        endcase
      end
      rvid_pkg::OPC_OP: begin
        dec_o.alu_en = 1'b1;
        dec_o.rf_we  = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec_o.alu_op = rvid_pkg::ALU_ADD;
          10'b0100000_000: dec_o.alu_op = rvid_pkg::ALU_SUB;
          10'b0000000_001: dec_o.alu_op = rvid_pkg::ALU_SLL;
          10'b0000000_010: dec_o.alu_op = rvid_pkg::ALU_SLT;
          10'b0000000_011: dec_o.alu_op = rvid_pkg::ALU_SLTU;
          10'b0000000_100: dec_o.alu_op = rvid_pkg::ALU_XOR;
          10'b0000000_101: dec_o.alu_op = rvid_pkg::ALU_SRL;
          10'b0100000_101: dec_o.alu_op = rvid_pkg::ALU_SRA;
          10'b0000000_110: dec_o.alu_op = rvid_pkg::ALU_OR;
          10'b0000000_111: dec_o.alu_op = rvid_pkg::ALU_AND;
          default:         dec_o.illegal = 1'b1;
        endcase
      end
      default: dec_o.illegal = 1'b1;
    endcase

    // An illegal instruction must leave no architectural trace
    if (dec_o.illegal) begin
      dec_o.alu_en   = 1'b0;
      dec_o.rf_we    = 1'b0;
      dec_o.data_req = 1'b0;
    end
  end

endmodule

// ==== design/rvid_pkg.sv ====
//////////////////////////////
// Opcode, ALU, mux select and control
// transfer enums, pipeline structs
//////////////////////////////
`include "rvid_macros.svh"

package rvid_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // RV32I major opcodes handled by the decoder
  typedef enum logic [`RVID_OPC_W-1:0] {
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_JALR   = 7'h67,
    OPC_BRANCH = 7'h63,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33
  } opcode_e;

  // Arithmetic ops first, branch compares after
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [0:0] {OP_B_REG, OP_B_IMM} op_b_sel_e;
  // Store data or branch target
  typedef enum logic [0:0] {OP_C_REG_B, OP_C_BCH_TARGET} op_c_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  // Chosen by the hazard logic outside this stage
  typedef enum logic [1:0] {FW_REGFILE, FW_EX, FW_WB} fw_sel_e;
  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_COND} ctrl_xfer_e;

  //////////////////////////////
  // Pipeline structs
  //////////////////////////////

  // Fetched instruction
  typedef struct packed {
    logic                  instr_valid;
    logic [`RVID_XLEN-1:0] instr;
    logic [`RVID_XLEN-1:0] pc;
  } if_id_t;

  // Register file and bypass values with their selects
  typedef struct packed {
    logic [`RVID_XLEN-1:0] rf_rdata_a;
    logic [`RVID_XLEN-1:0] rf_rdata_b;
    logic [`RVID_XLEN-1:0] wdata_ex;
    logic [`RVID_XLEN-1:0] wdata_wb;
    fw_sel_e               sel_a;
    fw_sel_e               sel_b;
  } fwd_data_t;

  // Decoder controls
  typedef struct packed {
    logic       alu_en;
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    op_c_sel_e  op_c_sel;
    imm_sel_e   imm_sel;
    logic       rf_we;
    logic       data_req;
    logic       data_we;
    logic [1:0] data_type;
    logic       data_sign_ext;
    ctrl_xfer_e ctrl_xfer;
    logic       illegal;
  } decode_t;

  // ID/EX word handed to the execute stage
  typedef struct packed {
    logic                    instr_valid;
    logic                    alu_en;
    alu_op_e                 alu_op;
    logic [`RVID_XLEN-1:0]   operand_a;
    logic [`RVID_XLEN-1:0]   operand_b;
    logic [`RVID_XLEN-1:0]   operand_c;
    logic                    rf_we;
    logic [`RVID_REG_AW-1:0] rf_waddr;
    logic                    data_req;
    logic                    data_we;
    logic [1:0]              data_type;
    logic                    data_sign_ext;
    logic                    branch_in_ex;
    logic                    illegal;
    logic [`RVID_XLEN-1:0]   pc;
  } id_ex_t;

  // One-cycle counter event pulses
  typedef struct packed {
    logic minstret;
    logic load;
    logic store;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
  } perf_evt_t;

endpackage

// ==== design/rvid_macros.svh ====
//////////////////////////////
// Width, field position and PC step
// constants of the decode stage
//////////////////////////////
`ifndef RVID_MACROS_SVH
`define RVID_MACROS_SVH

// Data and address width
`define RVID_XLEN     32
// Register file address width
`define RVID_REG_AW   5

// Source register 1 field
`define RVID_RS1_MSB  19
`define RVID_RS1_LSB  15
// Source register 2 field
`define RVID_RS2_MSB  24
`define RVID_RS2_LSB  20
// Destination register field
`define RVID_RD_MSB   11
`define RVID_RD_LSB   7

// Major opcode width
`define RVID_OPC_W    7
// Step to the next sequential instruction, no compressed support
`define RVID_PC_INCR  4

`endif
